//--- verilog/spec_pkg.sv
`default_nettype none

package spec_pkg;

    // input sample format
    localparam int DIN_WIDTH = 12;

    // spectrum geometry
    localparam int VECTOR_LEN = 16;
    localparam int BIN_WIDTH = $clog2(VECTOR_LEN);

    // full precision power of one complex sample
    localparam int POWER_WIDTH = 2 * DIN_WIDTH + 1;

    // scaling ahead of the accumulator, truncation only
    localparam int POWER_SHIFT = 4;
    localparam int ACC_DIN_WIDTH = 18;

    // accumulated bin, sized for acc_len up to 16384
    localparam int DOUT_WIDTH = 32;

    // signed real or imaginary component
    typedef logic signed [DIN_WIDTH-1:0] sample_t;

    // raw power, always non-negative
    typedef logic [POWER_WIDTH-1:0] power_t;

    // scaled and saturated power
    typedef logic [ACC_DIN_WIDTH-1:0] acc_in_t;

    // one accumulated bin
    typedef logic [DOUT_WIDTH-1:0] spec_t;

    // bin address within a vector
    typedef logic [BIN_WIDTH-1:0] bin_t;

    // saturation ceiling of the accumulator input
    localparam acc_in_t ACC_IN_MAX = '1;

endpackage

`default_nettype wire

//--- verilog/complex_power.sv
`timescale 1ns/1ps
`default_nettype none

module complex_power (
    input  wire              clk,
    input  wire              cnt_rst,
    input  wire spec_pkg::sample_t re,
    input  wire spec_pkg::sample_t im,
    input  wire              valid,
    input  wire              sync,
    output spec_pkg::power_t power,
    output logic             power_valid,
    output logic             power_sync
);

    import spec_pkg::*;

    // squares of a signed component are non-negative and fit in 2*DIN_WIDTH bits
    logic [2*DIN_WIDTH-1:0] sq_re;
    logic [2*DIN_WIDTH-1:0] sq_im;
    logic                   sq_valid;
    logic                   sq_sync;

    // stage one: the two squares
    always_ff @(posedge clk) begin
        sq_re <= re * re;
        sq_im <= im * im;
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            sq_valid <= 1'b0;
            sq_sync  <= 1'b0;
        end else begin
            sq_valid <= valid;
            sq_sync  <= sync & valid;
        end
    end

    // stage two: the sum, one extra bit absorbs the carry
    always_ff @(posedge clk) begin
        power <= power_t'(sq_re) + power_t'(sq_im);
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            power_valid <= 1'b0;
            power_sync  <= 1'b0;
        end else begin
            power_valid <= sq_valid;
            power_sync  <= sq_sync;
        end
    end

endmodule

`default_nettype wire

//--- verilog/power_resize.sv
`timescale 1ns/1ps
`default_nettype none

module power_resize (
    input  wire               clk,
    input  wire               cnt_rst,
    input  wire spec_pkg::power_t power,
    input  wire               power_valid,
    input  wire               power_sync,
    output spec_pkg::acc_in_t acc_in,
    output logic              acc_valid,
    output logic              acc_sync,
    output logic              sat
);

    import spec_pkg::*;

    // power after the fixed right shift, still full width
    power_t shifted;

    // shifted value does not fit in the accumulator input
    logic over;

    assign shifted = power >> POWER_SHIFT;
    assign over    = shifted > power_t'(ACC_IN_MAX);

    // clamp to the largest accumulator input
    always_ff @(posedge clk) begin
        if (over) begin
            acc_in <= ACC_IN_MAX;
        end else begin
            acc_in <= shifted[ACC_DIN_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            acc_valid <= 1'b0;
            acc_sync  <= 1'b0;
            sat       <= 1'b0;
        end else begin
            acc_valid <= power_valid;
            acc_sync  <= power_sync;
            // only a real sample may report saturation
            sat       <= over & power_valid;
        end
    end

    // the overflow pulse marks the same cycle as its sample
    sat_needs_valid: assert property (
        @(posedge clk) disable iff (cnt_rst)
        sat |-> acc_valid
    ) else $error("sat raised without acc_valid");

endmodule

`default_nettype wire

//--- verilog/acc_control.sv
`timescale 1ns/1ps
`default_nettype none

module acc_control (
    input  wire              clk,
    input  wire              cnt_rst,
    input  wire [31:0]       acc_len,
    input  wire              acc_valid,
    input  wire              acc_sync,
    output logic             sample_en,
    output spec_pkg::bin_t   bin,
    output logic             first_vec,
    output logic             last_vec
);

    import spec_pkg::*;

    // set once the frame has started
    logic        run;
    // sample position within one accumulation
    logic [31:0] pos;
    logic [31:0] pos_last;
    logic [31:0] last_vec_start;

    assign pos_last       = (acc_len << BIN_WIDTH) - 32'd1;
    assign last_vec_start = (acc_len - 32'd1) << BIN_WIDTH;

    // the sync sample itself already counts
    assign sample_en = acc_valid & (run | acc_sync);

    // a sync without its sample is ignored, later syncs change nothing
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            run <= 1'b0;
        end else if (acc_valid && acc_sync) begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            pos <= 32'd0;
        end else if (sample_en) begin
            if (pos == pos_last) begin
                pos <= 32'd0;
            end else begin
                pos <= pos + 32'd1;
            end
        end
    end

    assign bin       = pos[BIN_WIDTH-1:0];
    assign first_vec = pos < VECTOR_LEN;
    // with acc_len 1 the last vector is also the first
    assign last_vec  = pos >= last_vec_start;

    // zero length would never wrap the position counter
    acc_len_nonzero: assert property (
        @(posedge clk) disable iff (cnt_rst)
        run |-> acc_len != 32'd0
    ) else $error("acc_len is zero while accumulating");

endmodule

`default_nettype wire

//--- verilog/vector_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module vector_accumulator (
    input  wire               clk,
    input  wire               cnt_rst,
    input  wire spec_pkg::acc_in_t din,
    input  wire               sample_en,
    input  wire spec_pkg::bin_t   bin,
    input  wire               first_vec,
    input  wire               last_vec,
    output spec_pkg::spec_t   dout,
    output logic              dout_valid,
    output spec_pkg::bin_t    dout_addr
);

    import spec_pkg::*;

    // one running sum per bin
    spec_t mem [VECTOR_LEN];

    spec_t stored;
    spec_t sum;

    // read and write share the bin address
    assign stored = mem[bin];

    // first vector restarts the bin from the new sample
    always_comb begin
        if (first_vec) begin
            sum = spec_t'(din);
        end else begin
            sum = stored + spec_t'(din);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_en) begin
            mem[bin] <= sum;
        end
    end

    // finished bins leave during the last vector
    always_ff @(posedge clk) begin
        if (sample_en && last_vec) begin
            dout      <= sum;
            dout_addr <= bin;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= sample_en & last_vec;
        end
    end

    // back to back outputs walk the bins in order
    addr_in_order: assert property (
        @(posedge clk) disable iff (cnt_rst)
        dout_valid && $past(dout_valid) |-> dout_addr == bin_t'($past(dout_addr) + 1'b1)
    ) else $error("dout_addr out of order");

endmodule

`default_nettype wire

//--- verilog/spectrometer_lane.sv
`timescale 1ns/1ps
`default_nettype none

module spectrometer_lane (
    input  wire                clk,
    input  wire                cnt_rst,
    input  wire spec_pkg::sample_t din_re,
    input  wire spec_pkg::sample_t din_im,
    input  wire                din_valid,
    input  wire                sync_in,
    input  wire [31:0]         acc_len,
    output spec_pkg::spec_t    dout,
    output logic               dout_valid,
    output spec_pkg::bin_t     dout_addr,
    output logic               ovf_flag
);

    import spec_pkg::*;

    // input register
    sample_t re_r;
    sample_t im_r;
    logic    valid_r;
    logic    sync_r;

    // power stage
    power_t  power;
    logic    power_valid;
    logic    power_sync;

    // resize stage
    acc_in_t acc_in;
    logic    acc_valid;
    logic    acc_sync;
    logic    sat;

    // accumulation control
    logic    sample_en;
    bin_t    bin;
    logic    first_vec;
    logic    last_vec;

    always_ff @(posedge clk) begin
        re_r <= din_re;
        im_r <= din_im;
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            valid_r <= 1'b0;
            sync_r  <= 1'b0;
        end else begin
            valid_r <= din_valid;
            sync_r  <= sync_in;
        end
    end

    complex_power complex_power_i (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .re          (re_r),
        .im          (im_r),
        .valid       (valid_r),
        .sync        (sync_r),
        .power       (power),
        .power_valid (power_valid),
        .power_sync  (power_sync)
    );

    power_resize power_resize_i (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .power       (power),
        .power_valid (power_valid),
        .power_sync  (power_sync),
        .acc_in      (acc_in),
        .acc_valid   (acc_valid),
        .acc_sync    (acc_sync),
        .sat         (sat)
    );

    // combinational, lines up with acc_in
    acc_control acc_control_i (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .acc_len   (acc_len),
        .acc_valid (acc_valid),
        .acc_sync  (acc_sync),
        .sample_en (sample_en),
        .bin       (bin),
        .first_vec (first_vec),
        .last_vec  (last_vec)
    );

    vector_accumulator vector_accumulator_i (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .din        (acc_in),
        .sample_en  (sample_en),
        .bin        (bin),
        .first_vec  (first_vec),
        .last_vec   (last_vec),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_addr  (dout_addr)
    );

    assign ovf_flag = sat;

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RST_CYCLES  = 8
) (
    input  wire  rst_req,
    output logic clk,
    output logic cnt_rst
);

    // reset cycles still to go
    int rst_left;

    initial begin
        clk      = 1'b0;
        cnt_rst  = 1'b1;
        rst_left = RST_CYCLES;
    end

    always #(HALF_PERIOD) clk = ~clk;

    // a request restarts the whole reset window
    always @(posedge clk) begin
        if (rst_req) begin
            rst_left <= RST_CYCLES;
            cnt_rst  <= 1'b1;
        end else if (rst_left > 1) begin
            rst_left <= rst_left - 1;
        end else begin
            rst_left <= 0;
            cnt_rst  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tb/spectrometer_lane_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spectrometer_lane_tb;

    import spec_pkg::*;

    localparam int NUM_ROWS      = 8;
    localparam int EXTRA_SYNC_AT = 21;
    localparam int ABORT_TAIL    = 64;
    localparam int RESET_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 64;
    localparam int SETTLE_CYCLES = 12;
    // drive edge to the negedge that shows the matching ovf_flag
    localparam int OVF_LAG       = 5;

    // one case with its accumulation setup, stimulus shape and expected output count
    typedef struct packed {
        int acc_len;
        int n_acc;
        int amp_bits;
        int gap_period;
        int gap_en;
        int lead_in;
        int abort_at;
        int exp_outputs;
    } row_t;

    logic        clk;
    logic        cnt_rst;
    logic        rst_req;
    sample_t     din_re;
    sample_t     din_im;
    logic        din_valid;
    logic        sync_in;
    logic [31:0] acc_len;
    spec_t       dout;
    logic        dout_valid;
    bin_t        dout_addr;
    logic        ovf_flag;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr_state;
    int          cycle_cnt;

    // reference model state
    longint      acc_ref [VECTOR_LEN];
    int          frame_count;
    int          row_len;
    int          row_amp;
    int          outputs_seen;
    spec_t       exp_spec_q [$];
    bin_t        exp_addr_q [$];
    int          exp_ovf_q [$];

    int          value_errors;
    int          timeout_errors;
    int          other_errors;

    clock_gen clock_gen_i (
        .rst_req (rst_req),
        .clk     (clk),
        .cnt_rst (cnt_rst)
    );

    spectrometer_lane spectrometer_lane_i (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .sync_in    (sync_in),
        .acc_len    (acc_len),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_addr  (dout_addr),
        .ovf_flag   (ovf_flag)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // signed value of n random bits with one LFSR step per bit
    function automatic sample_t rand_sample(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        if (v >= (1 << (n - 1))) begin
            v = v - (1 << n);
        end
        return sample_t'(v);
    endfunction

    function automatic bit is_gap(input row_t row, input int cyc);
        return row.gap_en != 0 && (cyc % row.gap_period) == row.gap_period - 1;
    endfunction

    task automatic check_spec(input string name, input spec_t got, input spec_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input bin_t got, input bin_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ovf(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // rising edges since time zero
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // outputs are read half a cycle after the edge that set them
    always @(negedge clk) begin
        if (dout_valid === 1'b1) begin
            outputs_seen++;
            if (exp_spec_q.size() == 0) begin
                other_errors++;
                $display("dout_valid rose at address 0x%h with no result expected", dout_addr);
            end else begin
                check_spec("dout", dout, exp_spec_q.pop_front());
                check_addr("dout_addr", dout_addr, exp_addr_q.pop_front());
            end
        end
        if (exp_ovf_q.size() != 0 && exp_ovf_q[0] == cycle_cnt) begin
            check_ovf("ovf_flag", ovf_flag, 1'b1);
            void'(exp_ovf_q.pop_front());
        end else begin
            check_ovf("ovf_flag", ovf_flag, 1'b0);
        end
    end

    task automatic send_sample(input logic sync, input bit counted, input bit track);
        sample_t re;
        sample_t im;
        longint  scaled;
        longint  acc_max;
        int      pos;
        int      bin_idx;
        re = rand_sample(row_amp);
        im = rand_sample(row_amp);
        @(posedge clk);
        din_re    <= re;
        din_im    <= im;
        din_valid <= 1'b1;
        sync_in   <= sync;
        // power with truncating shift and clamp
        acc_max = (longint'(1) << ACC_DIN_WIDTH) - 1;
        scaled  = (longint'(re) * longint'(re) + longint'(im) * longint'(im)) >> POWER_SHIFT;
        if (scaled > acc_max) begin
            scaled = acc_max;
            if (track) begin
                exp_ovf_q.push_back(cycle_cnt + OVF_LAG);
            end
        end
        if (counted) begin
            pos     = frame_count % (row_len * VECTOR_LEN);
            bin_idx = pos % VECTOR_LEN;
            if (pos < VECTOR_LEN) begin
                acc_ref[bin_idx] = scaled;
            end else begin
                acc_ref[bin_idx] += scaled;
            end
            if (pos >= (row_len - 1) * VECTOR_LEN) begin
                exp_spec_q.push_back(spec_t'(acc_ref[bin_idx]));
                exp_addr_q.push_back(bin_t'(bin_idx));
            end
            frame_count++;
        end
    endtask

    task automatic drive_idle(input logic sync);
        @(posedge clk);
        din_valid <= 1'b0;
        sync_in   <= sync;
    endtask

    task automatic request_reset();
        @(posedge clk);
        rst_req   <= 1'b1;
        din_valid <= 1'b0;
        sync_in   <= 1'b0;
        @(posedge clk);
        rst_req <= 1'b0;
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (cnt_rst !== 1'b1 && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cnt_rst !== 1'b1) begin
            timeout_errors++;
            $display("timeout: cnt_rst was never asserted");
        end
        n = 0;
        while (cnt_rst !== 1'b0 && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cnt_rst !== 1'b0) begin
            timeout_errors++;
            $display("timeout: cnt_rst never released");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_spec_q.size() != 0 || exp_ovf_q.size() != 0) && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_spec_q.size() != 0 || exp_ovf_q.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d results and %0d overflow pulses never arrived",
                     exp_spec_q.size(), exp_ovf_q.size());
        end
        // stray pulses after the last result
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic run_row(input row_t row);
        int cyc;
        int lead;
        int sent;
        int total;
        request_reset();
        acc_len <= row.acc_len;
        wait_reset_done();
        row_len      = row.acc_len;
        row_amp      = row.amp_bits;
        frame_count  = 0;
        outputs_seen = 0;
        exp_spec_q.delete();
        exp_addr_q.delete();
        exp_ovf_q.delete();
        cyc  = 0;
        lead = 0;
        // lead-in samples that the DUT drops
        while (lead < row.lead_in) begin
            if (is_gap(row, cyc)) begin
                drive_idle(1'b0);
            end else begin
                send_sample(1'b0, 1'b0, 1'b1);
                lead++;
            end
            cyc++;
        end
        // sync with no valid sample must not start the frame
        if (row.lead_in > 0) begin
            drive_idle(1'b1);
        end
        total = (row.abort_at > 0) ? row.abort_at : row.acc_len * VECTOR_LEN * row.n_acc;
        sent  = 0;
        while (sent < total) begin
            if (sent > 0 && is_gap(row, cyc)) begin
                drive_idle(1'b0);
            end else begin
                send_sample(sent == 0 || sent == EXTRA_SYNC_AT, 1'b1, 1'b1);
                sent++;
            end
            cyc++;
        end
        if (row.abort_at > 0) begin
            // reset mid accumulation and then samples with no sync
            request_reset();
            repeat (ABORT_TAIL) send_sample(1'b0, 1'b0, 1'b0);
        end
        drive_idle(1'b0);
        wait_drain();
        check_count("dout_valid count", outputs_seen, row.exp_outputs);
    endtask

    initial begin
        rst_req        = 1'b0;
        din_re         = '0;
        din_im         = '0;
        din_valid      = 1'b0;
        sync_in        = 1'b0;
        acc_len        = 32'd1;
        lfsr_state     = 16'd85;
        cycle_cnt      = 0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        outputs_seen   = 0;
        // acc_len, n_acc, amp_bits, gap_period, gap_en, lead_in, abort_at, outputs
        rows[0] = '{1, 4, 8, 4, 0, 0, 0, 64};
        rows[1] = '{3, 2, 10, 4, 0, 5, 0, 32};
        rows[2] = '{4, 2, 10, 4, 0, 3, 0, 32};
        rows[3] = '{2, 3, 12, 4, 0, 7, 0, 48};
        rows[4] = '{1, 3, 12, 3, 1, 2, 0, 48};
        rows[5] = '{3, 2, 9, 5, 1, 4, 0, 32};
        rows[6] = '{4, 1, 8, 4, 0, 0, 20, 0};
        rows[7] = '{2, 2, 11, 4, 1, 1, 0, 32};
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("errors: %0d wrong values, %0d timeouts, %0d unexpected outputs",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/spec_pkg.sv
verilog/complex_power.sv
verilog/power_resize.sv
verilog/acc_control.sv
verilog/vector_accumulator.sv
verilog/spectrometer_lane.sv
tb/clock_gen.sv
tb/spectrometer_lane_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the spectrometer lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module spectrometer_lane_tb -o spectrometer_lane_sim

./obj_dir/spectrometer_lane_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
